//--- warp_looper_config.svh
`ifndef WARP_LOOPER_CONFIG_SVH
`define WARP_LOOPER_CONFIG_SVH

// ============================================================
// Datapath widths
// ============================================================

// One offset component, per dimension
`define WL_WBW 8
// Number of block dimensions walked by the looper
`define WL_VDIM 2
// Config id width, ids run from begin to end minus one
`define WL_NCFG_BW 4
// Shuffle order width, enough for a shift of 0..7
`define WL_CCV_BW 3

// ============================================================
// Warp and address limits
// ============================================================

// Up to 64 warps per job
`define WL_WID_BW 6
// Linear address is dim0 + pitch * dim1
`define WL_ROW_PITCH 256
`define WL_ADDR_BW 16

`endif

//--- warp_looper_pkg.sv
`default_nettype none

`include "warp_looper_config.svh"

package warp_looper_pkg;

	// ============================================================
	// Vector types
	// ============================================================

	// One offset per dimension, index 0 is the fastest dimension
	typedef logic [`WL_VDIM-1:0][`WL_WBW-1:0] ofs_vec_t;

	// Shuffle orders, one per dimension
	typedef logic [`WL_VDIM-1:0][`WL_CCV_BW-1:0] order_vec_t;

	// ============================================================
	// Index stage FSM
	// ============================================================

	// IDX_IDLE  no job held, input channel is acked
	// IDX_RUN   presenting an item that is not the final one
	// IDX_WAIT  presenting the final item, waiting for its ack
	typedef enum logic [1:0] {
		IDX_IDLE = 2'd0,
		IDX_RUN  = 2'd1,
		IDX_WAIT = 2'd2
	} idx_state_e;

endpackage

`default_nettype wire

//--- warp_looper_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

// Job as it enters the looper
interface job_if ();
	import warp_looper_pkg::*;

	logic                   rdy;
	logic                   ack;
	ofs_vec_t               bofs;
	ofs_vec_t               aofs;
	ofs_vec_t               alofs;
	ofs_vec_t               grid_step;
	order_vec_t             up_order;
	order_vec_t             lo_order;
	logic [`WL_NCFG_BW-1:0] id_beg;
	logic [`WL_NCFG_BW-1:0] id_end;
	logic [`WL_NCFG_BW-1:0] id_ret;
	logic                   islast;

	modport src (
		output rdy, bofs, aofs, alofs, grid_step, up_order, lo_order,
		output id_beg, id_end, id_ret, islast,
		input  ack
	);
	modport dst (
		input  rdy, bofs, aofs, alofs, grid_step, up_order, lo_order,
		input  id_beg, id_end, id_ret, islast,
		output ack
	);
endinterface

// Job with block bounds already resolved
interface range_if ();
	import warp_looper_pkg::*;

	logic                   rdy;
	logic                   ack;
	ofs_vec_t               beg;
	ofs_vec_t               end_;
	ofs_vec_t               aofs;
	ofs_vec_t               alofs;
	order_vec_t             up_order;
	order_vec_t             lo_order;
	logic [`WL_NCFG_BW-1:0] id_beg;
	logic [`WL_NCFG_BW-1:0] id_end;
	logic [`WL_NCFG_BW-1:0] id_ret;
	logic                   islast;

	modport src (
		output rdy, beg, end_, aofs, alofs, up_order, lo_order,
		output id_beg, id_end, id_ret, islast,
		input  ack
	);
	modport dst (
		input  rdy, beg, end_, aofs, alofs, up_order, lo_order,
		input  id_beg, id_end, id_ret, islast,
		output ack
	);
endinterface

// One warp item per config id and block position
interface item_if ();
	import warp_looper_pkg::*;

	logic                   rdy;
	logic                   ack;
	logic [`WL_NCFG_BW-1:0] id;
	logic [`WL_WID_BW-1:0]  warpid;
	ofs_vec_t               bofs;
	ofs_vec_t               blofs;
	ofs_vec_t               aofs;
	ofs_vec_t               alofs;
	logic                   retire;
	logic                   islast;

	modport src (
		output rdy, id, warpid, bofs, blofs, aofs, alofs, retire, islast,
		input  ack
	);
	modport dst (
		input  rdy, id, warpid, bofs, blofs, aofs, alofs, retire, islast,
		output ack
	);
endinterface

`default_nettype wire

//--- block_range_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module block_range_stage (
	input  logic i_clk,
	input  logic i_rst_n,
	job_if.dst   i_job,
	range_if.src o_rng
);
	import warp_looper_pkg::*;

	logic                   valid_r;
	logic                   job_take;
	ofs_vec_t               beg_w;
	ofs_vec_t               end_w;
	ofs_vec_t               beg_r;
	ofs_vec_t               end_r;
	ofs_vec_t               aofs_r;
	ofs_vec_t               alofs_r;
	order_vec_t             up_r;
	order_vec_t             lo_r;
	logic [`WL_NCFG_BW-1:0] id_beg_r;
	logic [`WL_NCFG_BW-1:0] id_end_r;
	logic [`WL_NCFG_BW-1:0] id_ret_r;
	logic                   islast_r;

	// Single entry, a new job only goes in once the held one has left
	assign i_job.ack = i_job.rdy && !valid_r;
	assign job_take  = i_job.ack;

	// Bounds are in units of the upper shuffle order
	always_comb begin
		for (int d = 0; d < `WL_VDIM; d++) begin
			beg_w[d] = i_job.bofs[d] >> i_job.up_order[d];
			end_w[d] = (i_job.bofs[d] + i_job.grid_step[d]) >> i_job.up_order[d];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_r <= 1'b0;
		end else if (job_take) begin
			valid_r <= 1'b1;
		end else if (o_rng.ack) begin
			valid_r <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (job_take) begin
			beg_r    <= beg_w;
			end_r    <= end_w;
			aofs_r   <= i_job.aofs;
			alofs_r  <= i_job.alofs;
			up_r     <= i_job.up_order;
			lo_r     <= i_job.lo_order;
			id_beg_r <= i_job.id_beg;
			id_end_r <= i_job.id_end;
			id_ret_r <= i_job.id_ret;
			islast_r <= i_job.islast;
		end
	end

	assign o_rng.rdy      = valid_r;
	assign o_rng.beg      = beg_r;
	assign o_rng.end_     = end_r;
	assign o_rng.aofs     = aofs_r;
	assign o_rng.alofs    = alofs_r;
	assign o_rng.up_order = up_r;
	assign o_rng.lo_order = lo_r;
	assign o_rng.id_beg   = id_beg_r;
	assign o_rng.id_end   = id_end_r;
	assign o_rng.id_ret   = id_ret_r;
	assign o_rng.islast   = islast_r;

endmodule

`default_nettype wire

//--- warp_index_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module warp_index_stage (
	input  logic i_clk,
	input  logic i_rst_n,
	range_if.dst i_rng,
	item_if.src  o_item
);
	import warp_looper_pkg::*;

	idx_state_e             state_r;
	idx_state_e             state_nxt;
	logic [`WL_NCFG_BW-1:0] id_r;
	logic [`WL_NCFG_BW-1:0] id_nxt;
	logic [`WL_WID_BW-1:0]  warpid_r;
	logic [`WL_WID_BW-1:0]  warpid_nxt;
	ofs_vec_t               blk_r;
	ofs_vec_t               blk_nxt;
	logic                   carry;
	ofs_vec_t               beg_r;
	ofs_vec_t               end_r;
	ofs_vec_t               aofs_r;
	ofs_vec_t               alofs_r;
	order_vec_t             up_r;
	order_vec_t             lo_r;
	logic [`WL_NCFG_BW-1:0] id_beg_r;
	logic [`WL_NCFG_BW-1:0] id_end_r;
	logic [`WL_NCFG_BW-1:0] id_ret_r;
	logic                   islast_r;
	logic                   rng_take;
	logic                   item_take;
	logic                   last_id;
	logic                   last_blk;

	// ============================================================
	// Helpers
	// ============================================================

	// Counter sits on end minus one in every dimension
	function automatic logic is_last_blk(input ofs_vec_t blk, input ofs_vec_t bend);
		logic r;
		r = 1'b1;
		for (int d = 0; d < `WL_VDIM; d++) begin
			if (blk[d] + 8'd1 != bend[d])
				r = 1'b0;
		end
		return r;
	endfunction

	function automatic logic is_final(
		input logic [`WL_NCFG_BW-1:0] id,
		input logic [`WL_NCFG_BW-1:0] id_end,
		input ofs_vec_t               blk,
		input ofs_vec_t               bend
	);
		return ((id + 1'b1) == id_end) && is_last_blk(blk, bend);
	endfunction

	// Zero insertion, e.g. ABCDE with up 2, lo 3 gives AB00CDE
	function automatic logic [`WL_WBW-1:0] vshuf(
		input logic [`WL_WBW-1:0]    v,
		input logic [`WL_CCV_BW-1:0] up,
		input logic [`WL_CCV_BW-1:0] lo
	);
		logic [`WL_WBW-1:0] hi_mask;
		hi_mask = {`WL_WBW{1'b1}} << lo;
		return (v & ~hi_mask) | ((v & hi_mask) << up);
	endfunction

	// ============================================================
	// Handshake and loop control
	// ============================================================

	assign i_rng.ack  = (state_r == IDX_IDLE) && i_rng.rdy;
	assign rng_take   = i_rng.ack;
	assign o_item.rdy = (state_r != IDX_IDLE);
	assign item_take  = o_item.rdy && o_item.ack;

	assign last_id  = (id_r + 1'b1) == id_end_r;
	assign last_blk = is_last_blk(blk_r, end_r);

	always_comb begin
		state_nxt  = state_r;
		id_nxt     = id_r;
		warpid_nxt = warpid_r;
		blk_nxt    = blk_r;
		carry      = 1'b1;
		if (rng_take) begin
			id_nxt     = i_rng.id_beg;
			warpid_nxt = '0;
			blk_nxt    = i_rng.beg;
			state_nxt  = is_final(i_rng.id_beg, i_rng.id_end, i_rng.beg, i_rng.end_) ?
				IDX_WAIT : IDX_RUN;
		end else if (item_take) begin
			if (state_r == IDX_WAIT) begin
				state_nxt = IDX_IDLE;
			end else begin
				if (last_id) begin
					// Inner id loop done, step the block counter, dim 0 fastest
					id_nxt     = id_beg_r;
					warpid_nxt = warpid_r + 1'b1;
					for (int d = 0; d < `WL_VDIM; d++) begin
						if (carry) begin
							if (blk_r[d] + 8'd1 == end_r[d]) begin
								blk_nxt[d] = beg_r[d];
							end else begin
								blk_nxt[d] = blk_r[d] + 8'd1;
								carry      = 1'b0;
							end
						end
					end
				end else begin
					id_nxt = id_r + 1'b1;
				end
				state_nxt = is_final(id_nxt, id_end_r, blk_nxt, end_r) ? IDX_WAIT : IDX_RUN;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r  <= IDX_IDLE;
			id_r     <= '0;
			warpid_r <= '0;
			blk_r    <= '0;
		end else begin
			state_r  <= state_nxt;
			id_r     <= id_nxt;
			warpid_r <= warpid_nxt;
			blk_r    <= blk_nxt;
		end
	end

	// Job fields, held for the whole walk
	always_ff @(posedge i_clk) begin
		if (rng_take) begin
			beg_r    <= i_rng.beg;
			end_r    <= i_rng.end_;
			aofs_r   <= i_rng.aofs;
			alofs_r  <= i_rng.alofs;
			up_r     <= i_rng.up_order;
			lo_r     <= i_rng.lo_order;
			id_beg_r <= i_rng.id_beg;
			id_end_r <= i_rng.id_end;
			id_ret_r <= i_rng.id_ret;
			islast_r <= i_rng.islast;
		end
	end

	// ============================================================
	// Item output
	// ============================================================

	assign o_item.id     = id_r;
	assign o_item.warpid = warpid_r;
	assign o_item.aofs   = aofs_r;
	assign o_item.alofs  = alofs_r;
	assign o_item.retire = last_blk && (id_r < id_ret_r);
	// WAIT means last block and last id
	assign o_item.islast = (state_r == IDX_WAIT) && islast_r;

	always_comb begin
		for (int d = 0; d < `WL_VDIM; d++) begin
			o_item.bofs[d]  = vshuf(blk_r[d], up_r[d], lo_r[d]);
			o_item.blofs[d] = vshuf(blk_r[d] - beg_r[d], up_r[d], lo_r[d]);
		end
	end

endmodule

`default_nettype wire

//--- address_issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module address_issue_stage (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	item_if.dst                       i_item,
	output logic                      o_dst_rdy,
	input  logic                      i_dst_ack,
	output logic [`WL_NCFG_BW-1:0]    o_id,
	output logic [`WL_WID_BW-1:0]     o_warpid,
	output warp_looper_pkg::ofs_vec_t o_bofs,
	output warp_looper_pkg::ofs_vec_t o_blofs,
	output warp_looper_pkg::ofs_vec_t o_aofs,
	output warp_looper_pkg::ofs_vec_t o_alofs,
	output logic                      o_retire,
	output logic                      o_islast,
	output logic [`WL_ADDR_BW-1:0]    o_addr
);

	localparam int ABW = `WL_ADDR_BW;

	logic           valid_r;
	logic           dst_take;
	logic           item_take;
	logic [ABW-1:0] col_w;
	logic [ABW-1:0] row_w;
	logic [ABW-1:0] addr_w;

	// ============================================================
	// Handshake
	// ============================================================

	assign dst_take  = valid_r && i_dst_ack;
	// Refill in the same cycle the held item leaves
	assign i_item.ack = i_item.rdy && (!valid_r || dst_take);
	assign item_take  = i_item.ack;
	assign o_dst_rdy  = valid_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_r <= 1'b0;
		end else if (item_take) begin
			valid_r <= 1'b1;
		end else if (dst_take) begin
			valid_r <= 1'b0;
		end
	end

	// ============================================================
	// Linear address
	// ============================================================

	always_comb begin
		col_w  = ABW'(i_item.aofs[0]) + ABW'(i_item.bofs[0]);
		row_w  = ABW'(i_item.aofs[1]) + ABW'(i_item.bofs[1]);
		// Wraps at 16 bits
		addr_w = col_w + row_w * ABW'(`WL_ROW_PITCH);
	end

	always_ff @(posedge i_clk) begin
		if (item_take) begin
			o_id     <= i_item.id;
			o_warpid <= i_item.warpid;
			o_bofs   <= i_item.bofs;
			o_blofs  <= i_item.blofs;
			o_aofs   <= i_item.aofs;
			o_alofs  <= i_item.alofs;
			o_retire <= i_item.retire;
			o_islast <= i_item.islast;
			o_addr   <= addr_w;
		end
	end

endmodule

`default_nettype wire

//--- warp_looper_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module warp_looper_top (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	// Job input channel
	input  logic                        i_src_rdy,
	output logic                        o_src_ack,
	input  warp_looper_pkg::ofs_vec_t   i_bofs,
	input  warp_looper_pkg::ofs_vec_t   i_aofs,
	input  warp_looper_pkg::ofs_vec_t   i_alofs,
	input  warp_looper_pkg::ofs_vec_t   i_bgrid_step,
	input  warp_looper_pkg::order_vec_t i_bsub_up_order,
	input  warp_looper_pkg::order_vec_t i_bsub_lo_order,
	input  logic [`WL_NCFG_BW-1:0]      i_id_beg,
	input  logic [`WL_NCFG_BW-1:0]      i_id_end,
	input  logic [`WL_NCFG_BW-1:0]      i_id_ret,
	input  logic                        i_islast,
	// Item output channel
	output logic                        o_dst_rdy,
	input  logic                        i_dst_ack,
	output logic [`WL_NCFG_BW-1:0]      o_id,
	output logic [`WL_WID_BW-1:0]       o_warpid,
	output warp_looper_pkg::ofs_vec_t   o_bofs,
	output warp_looper_pkg::ofs_vec_t   o_blofs,
	output warp_looper_pkg::ofs_vec_t   o_aofs,
	output warp_looper_pkg::ofs_vec_t   o_alofs,
	output logic                        o_retire,
	output logic                        o_islast,
	output logic [`WL_ADDR_BW-1:0]      o_addr
);

	job_if   job_ch ();
	range_if rng_ch ();
	item_if  item_ch ();

	// Plain ports onto the job channel
	assign job_ch.rdy       = i_src_rdy;
	assign o_src_ack        = job_ch.ack;
	assign job_ch.bofs      = i_bofs;
	assign job_ch.aofs      = i_aofs;
	assign job_ch.alofs     = i_alofs;
	assign job_ch.grid_step = i_bgrid_step;
	assign job_ch.up_order  = i_bsub_up_order;
	assign job_ch.lo_order  = i_bsub_lo_order;
	assign job_ch.id_beg    = i_id_beg;
	assign job_ch.id_end    = i_id_end;
	assign job_ch.id_ret    = i_id_ret;
	assign job_ch.islast    = i_islast;

	// ============================================================
	// Stages
	// ============================================================

	block_range_stage u_range (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_job   (job_ch.dst),
		.o_rng   (rng_ch.src)
	);

	warp_index_stage u_index (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rng   (rng_ch.dst),
		.o_item  (item_ch.src)
	);

	address_issue_stage u_issue (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_item    (item_ch.dst),
		.o_dst_rdy (o_dst_rdy),
		.i_dst_ack (i_dst_ack),
		.o_id      (o_id),
		.o_warpid  (o_warpid),
		.o_bofs    (o_bofs),
		.o_blofs   (o_blofs),
		.o_aofs    (o_aofs),
		.o_alofs   (o_alofs),
		.o_retire  (o_retire),
		.o_islast  (o_islast),
		.o_addr    (o_addr)
	);

endmodule

`default_nettype wire

//--- warp_looper_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module warp_looper_checker #(
	parameter int SRC_W = 4*`WL_VDIM*`WL_WBW + 2*`WL_VDIM*`WL_CCV_BW + 3*`WL_NCFG_BW + 1,
	parameter int DST_W = `WL_NCFG_BW + `WL_WID_BW + 4*`WL_VDIM*`WL_WBW + 2 + `WL_ADDR_BW
) (
	input logic             i_clk,
	input logic             i_rst_n,
	input logic             i_src_rdy,
	input logic             i_src_ack,
	input logic [SRC_W-1:0] i_src_data,
	input logic             i_dst_rdy,
	input logic             i_dst_ack,
	input logic [DST_W-1:0] i_dst_data
);

	// ============================================================
	// Ready/ack rules on both top-level channels
	// ============================================================

	a_src_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_src_rdy && !i_src_ack |=> i_src_rdy)
		else $error("Job rdy dropped before ack");

	a_src_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_src_rdy && !i_src_ack |=> $stable(i_src_data))
		else $error("Job fields changed while waiting for ack");

	a_dst_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dst_rdy && !i_dst_ack |=> i_dst_rdy)
		else $error("Item rdy dropped before ack");

	a_dst_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dst_rdy && !i_dst_ack |=> $stable(i_dst_data))
		else $error("Item fields changed while waiting for ack");

	a_dst_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_dst_rdy |-> !i_dst_ack)
		else $error("Item ack without rdy");

	// Quiet outputs while reset is held
	a_reset_idle: assert property (@(posedge i_clk)
		!i_rst_n |-> !i_dst_rdy && !i_src_ack)
		else $error("Handshake output active during reset");

endmodule

bind warp_looper_top warp_looper_checker checker_i (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_src_rdy  (i_src_rdy),
	.i_src_ack  (o_src_ack),
	.i_src_data ({i_bofs, i_aofs, i_alofs, i_bgrid_step, i_bsub_up_order, i_bsub_lo_order,
		i_id_beg, i_id_end, i_id_ret, i_islast}),
	.i_dst_rdy  (o_dst_rdy),
	.i_dst_ack  (i_dst_ack),
	.i_dst_data ({o_id, o_warpid, o_bofs, o_blofs, o_aofs, o_alofs, o_retire, o_islast,
		o_addr})
);

`default_nettype wire

//--- warp_looper_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module warp_looper_scoreboard (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_dst_rdy,
	input  logic                      i_dst_ack,
	input  logic [`WL_NCFG_BW-1:0]    i_id,
	input  logic [`WL_WID_BW-1:0]     i_warpid,
	input  warp_looper_pkg::ofs_vec_t i_bofs,
	input  warp_looper_pkg::ofs_vec_t i_blofs,
	input  warp_looper_pkg::ofs_vec_t i_aofs,
	input  warp_looper_pkg::ofs_vec_t i_alofs,
	input  logic                      i_retire,
	input  logic                      i_islast,
	input  logic [`WL_ADDR_BW-1:0]    i_addr,
	output int                        o_err_cnt,
	output int                        o_item_cnt,
	output int                        o_job_cnt
);
	import warp_looper_pkg::*;

	typedef struct packed {
		logic [`WL_NCFG_BW-1:0] id;
		logic [`WL_WID_BW-1:0]  warpid;
		ofs_vec_t               bofs;
		ofs_vec_t               blofs;
		ofs_vec_t               aofs;
		ofs_vec_t               alofs;
		logic                   retire;
		logic                   islast;
		logic [`WL_ADDR_BW-1:0] addr;
	} exp_item_t;

	exp_item_t exp_q[$];
	int        job_len[$];
	int        job_items;
	int        job_err_base;

	// ============================================================
	// Loading from the golden file reader
	// ============================================================

	task push_job();
		job_len.push_back(0);
	endtask

	task push_item(
		input logic [`WL_NCFG_BW-1:0] id,
		input logic [`WL_WID_BW-1:0]  warpid,
		input ofs_vec_t               bofs,
		input ofs_vec_t               blofs,
		input ofs_vec_t               aofs,
		input ofs_vec_t               alofs,
		input logic                   retire,
		input logic                   islast,
		input logic [`WL_ADDR_BW-1:0] addr
	);
		exp_item_t e;
		e = '{id, warpid, bofs, blofs, aofs, alofs, retire, islast, addr};
		exp_q.push_back(e);
		if (job_len.size() == 0)
			job_len.push_back(0);
		job_len[job_len.size()-1] += 1;
	endtask

	task check_field(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h (job %0d, item %0d)",
				name, got, exp, o_job_cnt, job_items);
			o_err_cnt++;
		end
	endtask

	// ============================================================
	// Compare on every accepted item
	// ============================================================

	always @(posedge i_clk) begin
		exp_item_t e;
		if (i_rst_n && i_dst_rdy && i_dst_ack) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected item from the DUT, no expected item is left");
				o_err_cnt++;
			end else begin
				e = exp_q.pop_front();
				check_field("o_id", 16'(i_id), 16'(e.id));
				check_field("o_warpid", 16'(i_warpid), 16'(e.warpid));
				check_field("o_bofs", i_bofs, e.bofs);
				check_field("o_blofs", i_blofs, e.blofs);
				check_field("o_aofs", i_aofs, e.aofs);
				check_field("o_alofs", i_alofs, e.alofs);
				check_field("o_retire", 16'(i_retire), 16'(e.retire));
				check_field("o_islast", 16'(i_islast), 16'(e.islast));
				check_field("o_addr", i_addr, e.addr);
				o_item_cnt++;
				job_items++;
				// Job boundary comes from the item count per golden job
				if (job_items == job_len[o_job_cnt]) begin
					$display("Job %0d finished: %0d items, %0d errors",
						o_job_cnt, job_items, o_err_cnt - job_err_base);
					o_job_cnt++;
					job_items    = 0;
					job_err_base = o_err_cnt;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_warp_looper.sv
`timescale 1ns/100ps
`default_nettype none

`include "warp_looper_config.svh"

module tb_warp_looper;
	import warp_looper_pkg::*;

	localparam int ACCEPT_LIMIT = 2000;
	localparam int DRAIN_LIMIT  = 4000;

	typedef struct packed {
		ofs_vec_t               bofs;
		ofs_vec_t               aofs;
		ofs_vec_t               alofs;
		ofs_vec_t               step;
		order_vec_t             up;
		order_vec_t             lo;
		logic [`WL_NCFG_BW-1:0] id_beg;
		logic [`WL_NCFG_BW-1:0] id_end;
		logic [`WL_NCFG_BW-1:0] id_ret;
		logic                   islast;
	} job_t;

	logic                   i_clk = 1'b0;
	logic                   i_rst_n;
	logic                   i_src_rdy;
	logic                   o_src_ack;
	ofs_vec_t               i_bofs;
	ofs_vec_t               i_aofs;
	ofs_vec_t               i_alofs;
	ofs_vec_t               i_bgrid_step;
	order_vec_t             i_bsub_up_order;
	order_vec_t             i_bsub_lo_order;
	logic [`WL_NCFG_BW-1:0] i_id_beg;
	logic [`WL_NCFG_BW-1:0] i_id_end;
	logic [`WL_NCFG_BW-1:0] i_id_ret;
	logic                   i_islast;
	logic                   o_dst_rdy;
	logic                   i_dst_ack = 1'b0;
	logic [`WL_NCFG_BW-1:0] o_id;
	logic [`WL_WID_BW-1:0]  o_warpid;
	ofs_vec_t               o_bofs;
	ofs_vec_t               o_blofs;
	ofs_vec_t               o_aofs;
	ofs_vec_t               o_alofs;
	logic                   o_retire;
	logic                   o_islast;
	logic [`WL_ADDR_BW-1:0] o_addr;

	integer seed = 27534;
	job_t   jobs[$];
	int     total_items;
	int     err_cnt;
	int     item_cnt;
	int     job_cnt;

	always #4 i_clk = ~i_clk;

	warp_looper_top warp_looper_top_i (.*);

	warp_looper_scoreboard sb_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_dst_rdy  (o_dst_rdy),
		.i_dst_ack  (i_dst_ack),
		.i_id       (o_id),
		.i_warpid   (o_warpid),
		.i_bofs     (o_bofs),
		.i_blofs    (o_blofs),
		.i_aofs     (o_aofs),
		.i_alofs    (o_alofs),
		.i_retire   (o_retire),
		.i_islast   (o_islast),
		.i_addr     (o_addr),
		.o_err_cnt  (err_cnt),
		.o_item_cnt (item_cnt),
		.o_job_cnt  (job_cnt)
	);

	// Random gaps on the downstream ack, only while an item is offered
	always @(posedge i_clk) begin
		#1;
		if (!i_rst_n)
			i_dst_ack = 1'b0;
		else
			i_dst_ack = o_dst_rdy && (($random(seed) & 3) != 0);
	end

	// ============================================================
	// Golden file reader and job driver
	// ============================================================

	task read_golden(output logic ok);
		int              fd;
		int              n;
		logic [63:0]     tag;
		logic [8*128-1:0] rest;
		logic [15:0]     f [0:15];
		logic [15:0]     g [0:8];
		job_t            j;
		ofs_vec_t        cur_aofs;
		ofs_vec_t        cur_alofs;
		ok = 1'b1;
		cur_aofs = '0;
		cur_alofs = '0;
		fd = $fopen("warp_looper_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open warp_looper_golden.txt");
			ok = 1'b0;
			return;
		end
		while (ok && !$feof(fd)) begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1)
				break;
			if (tag == "#") begin
				n = $fgets(rest, fd);
			end else if (tag == "J") begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
				if (n != 16) begin
					$display("Malformed job line in the golden file");
					ok = 1'b0;
				end else begin
					j.bofs   = {f[1][7:0], f[0][7:0]};
					j.aofs   = {f[3][7:0], f[2][7:0]};
					j.alofs  = {f[5][7:0], f[4][7:0]};
					j.step   = {f[7][7:0], f[6][7:0]};
					j.up     = {f[9][2:0], f[8][2:0]};
					j.lo     = {f[11][2:0], f[10][2:0]};
					j.id_beg = f[12][3:0];
					j.id_end = f[13][3:0];
					j.id_ret = f[14][3:0];
					j.islast = f[15][0];
					jobs.push_back(j);
					cur_aofs  = j.aofs;
					cur_alofs = j.alofs;
					sb_i.push_job();
				end
			end else if (tag == "I") begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
					g[0], g[1], g[2], g[3], g[4], g[5], g[6], g[7], g[8]);
				if (n != 9) begin
					$display("Malformed item line in the golden file");
					ok = 1'b0;
				end else begin
					sb_i.push_item(g[0][3:0], g[1][5:0], {g[3][7:0], g[2][7:0]},
						{g[5][7:0], g[4][7:0]}, cur_aofs, cur_alofs, g[6][0], g[7][0], g[8]);
					total_items++;
				end
			end else begin
				$display("Unknown line tag in the golden file");
				ok = 1'b0;
			end
		end
		$fclose(fd);
	endtask

	// Called just after a rising edge, returns the same way
	task drive_job(input job_t j, input int idx, output logic ok);
		int   cnt;
		logic taken;
		i_bofs          = j.bofs;
		i_aofs          = j.aofs;
		i_alofs         = j.alofs;
		i_bgrid_step    = j.step;
		i_bsub_up_order = j.up;
		i_bsub_lo_order = j.lo;
		i_id_beg        = j.id_beg;
		i_id_end        = j.id_end;
		i_id_ret        = j.id_ret;
		i_islast        = j.islast;
		i_src_rdy       = 1'b1;
		taken = 1'b0;
		cnt   = 0;
		while (!taken && cnt < ACCEPT_LIMIT) begin
			@(posedge i_clk);
			if (o_src_ack)
				taken = 1'b1;
			else
				cnt++;
		end
		#1;
		i_src_rdy = 1'b0;
		ok = taken;
		if (!taken)
			$display("Timeout: job %0d was not accepted within %0d cycles", idx, ACCEPT_LIMIT);
	endtask

	initial begin
		logic ok;
		int   cnt;
		i_rst_n         = 1'b0;
		i_src_rdy       = 1'b0;
		i_bofs          = '0;
		i_aofs          = '0;
		i_alofs         = '0;
		i_bgrid_step    = '0;
		i_bsub_up_order = '0;
		i_bsub_lo_order = '0;
		i_id_beg        = '0;
		i_id_end        = '0;
		i_id_ret        = '0;
		i_islast        = 1'b0;
		read_golden(ok);
		repeat (8) @(posedge i_clk);
		#1 i_rst_n = 1'b1;
		for (int i = 0; i < jobs.size() && ok; i++)
			drive_job(jobs[i], i, ok);
		if (ok) begin
			cnt = 0;
			while (item_cnt < total_items && cnt < DRAIN_LIMIT) begin
				@(negedge i_clk);
				cnt++;
			end
			if (item_cnt < total_items) begin
				$display("Timeout: only %0d of %0d items came out", item_cnt, total_items);
				ok = 1'b0;
			end else begin
				// Extra items would show up here as unexpected
				repeat (16) @(posedge i_clk);
			end
		end
		$display("Summary: %0d jobs, %0d items, %0d errors", job_cnt, item_cnt, err_cnt);
		if (ok && err_cnt == 0 && total_items > 0 && item_cnt == total_items &&
			job_cnt == jobs.size()) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- warp_looper_top.f
+incdir+.
warp_looper_pkg.sv
warp_looper_if.sv
block_range_stage.sv
warp_index_stage.sv
address_issue_stage.sv
warp_looper_top.sv
warp_looper_checker.sv
warp_looper_scoreboard.sv
tb_warp_looper.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the warp looper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_warp_looper \
	-f warp_looper_top.f \
	--Mdir obj_dir -o tb_warp_looper_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_warp_looper_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "Test completed successfully" "$LOG"; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1

//--- warp_looper_golden.txt
# J bofs0 bofs1 aofs0 aofs1 alofs0 alofs1 step0 step1 up0 up1 lo0 lo1 id_beg id_end id_ret islast
# I id warpid bofs0 bofs1 blofs0 blofs1 retire islast addr  (hex, items follow their job)
# Plain loop, one block, ids 2 to 4
J 10 20 01 02 03 04 01 01 0 0 0 0 2 5 4 1
I 2 00 10 20 00 00 1 0 2211
I 3 00 10 20 00 00 1 0 2211
I 4 00 10 20 00 00 0 1 2211
# Two by two blocks, dim 0 fastest
J 04 08 00 00 05 06 02 02 0 0 0 0 0 2 1 1
I 0 00 04 08 00 00 0 0 0804
I 1 00 04 08 00 00 0 0 0804
I 0 01 05 08 01 00 0 0 0805
I 1 01 05 08 01 00 0 0 0805
I 0 02 04 09 00 01 0 0 0904
I 1 02 04 09 00 01 0 0 0904
I 0 03 05 09 01 01 1 0 0905
I 1 03 05 09 01 01 0 1 0905
# Shuffle with zero insertion
J 1C 06 10 01 00 00 08 02 2 1 2 0 5 6 6 1
I 5 00 13 06 00 00 0 0 0723
I 5 01 20 06 01 00 1 1 0730
# Retire below id_ret on the last block, job islast clear
J 00 00 00 00 00 00 02 01 0 0 0 0 1 4 3 0
I 1 00 00 00 00 00 0 0 0000
I 2 00 00 00 00 00 0 0 0000
I 3 00 00 00 00 00 0 0 0000
I 1 01 01 00 01 00 1 0 0001
I 2 01 01 00 01 00 1 0 0001
I 3 01 01 00 01 00 0 0 0001
# Back to back jobs, address wraps at 16 bits
J 30 40 F0 FF 00 00 01 02 0 0 0 0 0 1 1 1
I 0 00 30 40 00 00 0 0 4020
I 0 01 30 41 00 01 1 1 4120
J 02 01 00 00 00 00 01 01 0 0 0 0 7 8 0 0
I 7 00 02 01 00 00 0 0 0102
J 05 00 01 01 00 00 02 01 0 0 0 0 0 1 2 1
I 0 00 05 00 00 00 0 0 0106
I 0 01 06 00 01 00 1 1 0107
